// File: list.f
+incdir+design
design/bus_types_pkg.sv
design/arb_pkg.sv
design/credit_counter.sv
design/bus_arbiter_fsm.sv
design/store_lane_align.sv
design/rsp_router.sv
design/clint_timer.sv
design/mem_bus_top.sv
tests/mem_bus_properties.sv
tests/tb_mem_bus.sv

// File: run.sh
#!/usr/bin/env bash
# build and run, exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_mem_bus \
  -o Vtb_mem_bus && \
  ./obj_dir/Vtb_mem_bus || exit 1

// File: tests/tb_mem_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_macros.svh"

module tb_mem_bus;

  import bus_types_pkg::*;

  localparam int n_ops = 300;
  localparam int cyc_limit = n_ops * 12;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic ifu_req_i = 1'b0;
  addr_t ifu_addr_i = '0;
  logic lsu_rd_req_i = 1'b0;
  logic lsu_wr_req_i = 1'b0;
  addr_t lsu_addr_i = '0;
  word_t lsu_wdata_i = '0;
  lane_strb_t lsu_strb_i = '0;
  logic mem_credit_i = 1'b0;
  logic mem_rsp_valid_i = 1'b0;
  beat_t mem_rdata_i = '0;
  logic ifu_ack_o;
  logic ifu_rvalid_o;
  logic lsu_ack_o;
  logic lsu_rvalid_o;
  logic lsu_wdone_o;
  word_t ifu_rdata_o;
  word_t lsu_rdata_o;
  logic mem_req_o;
  logic mem_we_o;
  addr_t mem_addr_o;
  size_t mem_size_o;
  beat_t mem_wdata_o;
  beat_strb_t mem_wstrb_o;

  mem_bus_top mem_bus_top_inst (.*);

  always #5 clk = ~clk;

  initial
  begin
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  integer seed = 12;
  logic [31:0] rnd;
  // responder memory holds beats and the model memory holds words
  beat_t mem_beats [32];
  word_t ref_mem [64];
  int pend_st [64];
  // accepted requests, oldest first
  addr_t rq_addr [$];
  beat_t rq_wdata [$];
  beat_strb_t rq_strb [$];
  int rq_due [$];
  // owner kind where 0 is an ifu read, 1 an lsu read and 2 an lsu write
  int rq_kind [$];
  // owner kind of the response on the bus or -1 for none
  int rsp_kind;
  word_t ifu_exp [$];
  word_t lsu_exp [$];
  logic [5:0] wd_exp [$];
  int credits;
  int cyc;
  int stall;
  int streak;
  int ifu_sent;
  int ifu_acked;
  int lsu_sent;
  int lsu_acked;
  logic [63:0] tcount;
  logic clint_due;
  // next lsu op where kind 0 is a timer load, 1 a store and 2 a load
  logic op_valid = 1'b0;
  int op_kind;
  logic [5:0] op_word;
  logic [1:0] op_off;
  size_t op_size;
  lane_strb_t op_strb;
  word_t op_wdata;
  logic op_hi;
  word_t shifted;

  function automatic word_t fill_word(int idx);
    return 32'h1357_9bdf ^ (32'(idx) * 32'h0101_0107);
  endfunction

  task automatic check_value(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_with(string msg);
    $display("%s at %0t", msg, $time);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc > cyc_limit)
    begin
      fail_with("timeout, operations did not complete");
    end
    mem_rsp_valid_i <= 1'b0;
    mem_credit_i <= 1'b0;
    if (rst)
    begin
      // fill pattern over the whole word address
      for (int i = 0; i < 64; i++)
      begin
        ref_mem[i] = fill_word(i);
        pend_st[i] = 0;
      end
      for (int j = 0; j < 32; j++)
      begin
        mem_beats[j] = {fill_word(2 * j + 1), fill_word(2 * j)};
      end
      credits = `MB_CREDITS;
      tcount <= '0;
      clint_due = 1'b0;
      rsp_kind = -1;
      stall = 0;
      streak = 0;
      cyc <= 0;
      ifu_sent = 0;
      ifu_acked = 0;
      lsu_sent = 0;
      lsu_acked = 0;
    end
    else
    begin
      tcount <= tcount + 64'd1;
      rnd = $random(seed);
      // the response of the last cycle pulses exactly its owner's output
      check_value("ifu_rvalid_o", {31'd0, ifu_rvalid_o}, {31'd0, rsp_kind == 0});
      check_value("lsu_wdone_o", {31'd0, lsu_wdone_o}, {31'd0, rsp_kind == 2});
      if (rsp_kind == 1)
      begin
        check_value("lsu_rvalid_o", {31'd0, lsu_rvalid_o}, 32'd1);
      end
      rsp_kind = -1;
      // accept requests on the memory side
      if (mem_req_o)
      begin
        if (credits == 0)
        begin
          fail_with("memory request arrived with no credit");
        end
        credits = credits - 1;
        rq_addr.push_back(mem_addr_o);
        rq_wdata.push_back(mem_wdata_o);
        rq_strb.push_back(mem_wstrb_o);
        rq_due.push_back(cyc + 1 + int'(rnd[2:0] % 3'd5));
        rq_kind.push_back(ifu_ack_o ? 0 : (lsu_wr_req_i ? 2 : 1));
      end
      // in order responses from memory with rare long stalls
      if (stall > 0)
      begin
        stall = stall - 1;
      end
      else if (rnd[15:9] == 7'd0)
      begin
        stall = 16;
      end
      else if (rq_addr.size() > 0 && cyc >= rq_due[0])
      begin
        for (int b = 0; b < 8; b++)
        begin
          if (rq_strb[0][b])
          begin
            mem_beats[rq_addr[0][7:3]][b*8 +: 8] = rq_wdata[0][b*8 +: 8];
          end
        end
        mem_rdata_i <= mem_beats[rq_addr[0][7:3]];
        mem_rsp_valid_i <= 1'b1;
        mem_credit_i <= 1'b1;
        credits = credits + 1;
        rsp_kind = rq_kind.pop_front();
        void'(rq_addr.pop_front());
        void'(rq_wdata.pop_front());
        void'(rq_strb.pop_front());
        void'(rq_due.pop_front());
      end
      // responses to the core
      if (ifu_rvalid_o)
      begin
        if (ifu_exp.size() == 0)
        begin
          fail_with("fetch response with nothing outstanding");
        end
        check_value("ifu_rdata_o", ifu_rdata_o, ifu_exp.pop_front());
      end
      if (clint_due)
      begin
        check_value("lsu_rvalid_o", {31'd0, lsu_rvalid_o}, 32'd1);
        clint_due = 1'b0;
      end
      if (lsu_rvalid_o)
      begin
        if (lsu_exp.size() == 0)
        begin
          fail_with("load response with nothing outstanding");
        end
        check_value("lsu_rdata_o", lsu_rdata_o, lsu_exp.pop_front());
      end
      if (lsu_wdone_o)
      begin
        if (wd_exp.size() == 0)
        begin
          fail_with("store done with no store outstanding");
        end
        pend_st[wd_exp[0]] = pend_st[wd_exp[0]] - 1;
        void'(wd_exp.pop_front());
      end
      // ifu must not lose two grants in a row
      if (ifu_ack_o || !ifu_req_i)
      begin
        streak = 0;
      end
      else if (lsu_ack_o)
      begin
        streak = streak + 1;
        if (streak >= 2)
        begin
          fail_with("fetch starved by two lsu grants in a row");
        end
      end
      // ifu requester on words 0 to 31
      if (ifu_ack_o)
      begin
        check_value("mem_req_o", {31'd0, mem_req_o}, 32'd1);
        check_value("mem_we_o", {31'd0, mem_we_o}, 32'd0);
        check_value("mem_size_o", {29'd0, mem_size_o}, 32'd2);
        ifu_exp.push_back(ref_mem[ifu_addr_i[7:2]]);
        ifu_acked = ifu_acked + 1;
      end
      if (!ifu_req_i || ifu_ack_o)
      begin
        if (ifu_sent < n_ops && rnd[17:16] != 2'b00)
        begin
          ifu_req_i <= 1'b1;
          ifu_addr_i <= {25'd0, rnd[22:18], 2'b00};
          ifu_sent = ifu_sent + 1;
        end
        else
        begin
          ifu_req_i <= 1'b0;
        end
      end
      // model update on an lsu ack
      if (lsu_ack_o)
      begin
        if (op_kind == 0)
        begin
          check_value("mem_req_o", {31'd0, mem_req_o}, 32'd0);
          lsu_exp.push_back(op_hi ? tcount[63:32] : tcount[31:0]);
          clint_due = 1'b1;
        end
        else
        begin
          check_value("mem_req_o", {31'd0, mem_req_o}, 32'd1);
          check_value("mem_we_o", {31'd0, mem_we_o}, {31'd0, op_kind == 1});
          check_value("mem_size_o", {29'd0, mem_size_o}, {29'd0, op_size});
        end
        if (op_kind == 1)
        begin
          shifted = op_wdata << {op_off, 3'b000};
          for (int b = 0; b < 4; b++)
          begin
            if (op_strb[b])
            begin
              ref_mem[op_word][b*8 +: 8] = shifted[b*8 +: 8];
            end
          end
          wd_exp.push_back(op_word);
          pend_st[op_word] = pend_st[op_word] + 1;
        end
        if (op_kind == 2)
        begin
          lsu_exp.push_back(ref_mem[op_word]);
        end
        op_valid = 1'b0;
        lsu_acked = lsu_acked + 1;
      end
      // lsu requester on words 32 to 63 and the timer
      rnd = $random(seed);
      if (!op_valid && lsu_sent < n_ops && rnd[0])
      begin
        op_kind = (rnd[3:1] == 3'd0) ? 0 : ((rnd[3:1] < 3'd4) ? 1 : 2);
        op_word = {1'b1, rnd[8:4]};
        op_size = (rnd[10:9] == 2'd3) ? 3'd2 : {1'b0, rnd[10:9]};
        op_off = (op_size == 3'd0) ? rnd[12:11] :
                 (op_size == 3'd1) ? {rnd[12], 1'b0} : 2'b00;
        op_strb = (op_size == 3'd0) ? 4'b0001 : (op_size == 3'd1) ? 4'b0011 : 4'b1111;
        op_strb = op_strb << op_off;
        op_hi = rnd[13];
        op_wdata = $random(seed);
        op_valid = 1'b1;
        lsu_sent = lsu_sent + 1;
      end
      if ((!lsu_rd_req_i && !lsu_wr_req_i) || lsu_ack_o)
      begin
        if (op_valid && (op_kind != 2 || pend_st[op_word] == 0))
        begin
          lsu_rd_req_i <= (op_kind != 1);
          lsu_wr_req_i <= (op_kind == 1);
          lsu_addr_i <= (op_kind == 0) ? (op_hi ? `MB_RTC_ADDR_UP : `MB_RTC_ADDR) :
                        {24'd0, op_word, op_off};
          lsu_wdata_i <= op_wdata;
          lsu_strb_i <= op_strb;
        end
        else
        begin
          lsu_rd_req_i <= 1'b0;
          lsu_wr_req_i <= 1'b0;
        end
      end
      // all ops acked and answered
      if (ifu_acked == n_ops && lsu_acked == n_ops && ifu_exp.size() == 0 &&
          lsu_exp.size() == 0 && wd_exp.size() == 0 && rq_addr.size() == 0 && !clint_due)
      begin
        $display("test passed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/mem_bus_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_macros.svh"

module mem_bus_properties (
  input wire logic                    clk,
  input wire logic                    rst,
  input wire logic [`MB_CREDIT_W-1:0] credit_count_i,
  input wire logic                    has_credit_i,
  input wire logic                    mem_req_i,
  input wire logic                    ifu_ack_i,
  input wire logic                    lsu_ack_i
);

  // free credits stay within what memory handed out
  credit_max_a: assert property (@(posedge clk) disable iff (rst)
    credit_count_i <= `MB_CREDITS)
    else $error("credit count above limit");

  // a memory request always spends a held credit
  req_credit_a: assert property (@(posedge clk) disable iff (rst)
    mem_req_i |-> has_credit_i)
    else $error("memory request without credit");

  // one grant per cycle
  one_ack_a: assert property (@(posedge clk) disable iff (rst)
    !(ifu_ack_i && lsu_ack_i))
    else $error("both ports acked together");

  // quiet bus in reset
  reset_quiet_a: assert property (@(posedge clk)
    rst |-> !(ifu_ack_i || lsu_ack_i || mem_req_i))
    else $error("ack or request during reset");

endmodule

bind mem_bus_top mem_bus_properties mem_bus_properties_inst (
  .clk            (clk),
  .rst            (rst),
  .credit_count_i (credit_counter_inst.count_q),
  .has_credit_i   (has_credit),
  .mem_req_i      (mem_req_o),
  .ifu_ack_i      (ifu_ack_o),
  .lsu_ack_i      (lsu_ack_o)
);

`default_nettype wire

// File: design/mem_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_top (
  input  logic                      clk,
  input  logic                      rst,
  // instruction fetch port
  input  logic                      ifu_req_i,
  input  bus_types_pkg::addr_t      ifu_addr_i,
  output logic                      ifu_ack_o,
  output logic                      ifu_rvalid_o,
  output bus_types_pkg::word_t      ifu_rdata_o,
  // load/store port
  input  logic                      lsu_rd_req_i,
  input  logic                      lsu_wr_req_i,
  input  bus_types_pkg::addr_t      lsu_addr_i,
  input  bus_types_pkg::word_t      lsu_wdata_i,
  input  bus_types_pkg::lane_strb_t lsu_strb_i,
  output logic                      lsu_ack_o,
  output logic                      lsu_rvalid_o,
  output bus_types_pkg::word_t      lsu_rdata_o,
  output logic                      lsu_wdone_o,
  // credit based memory channel
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output bus_types_pkg::addr_t      mem_addr_o,
  output bus_types_pkg::size_t      mem_size_o,
  output bus_types_pkg::beat_t      mem_wdata_o,
  output bus_types_pkg::beat_strb_t mem_wstrb_o,
  input  logic                      mem_credit_i,
  input  logic                      mem_rsp_valid_i,
  input  bus_types_pkg::beat_t      mem_rdata_i
);

  import arb_pkg::*;
  import bus_types_pkg::*;

  logic   has_credit;
  logic   issue;
  logic   idle;
  owner_t grant;
  logic   clint_rd;
  logic   rtr_lsu_rvalid;
  word_t  rtr_lsu_rdata;
  logic   clint_rvalid;
  word_t  clint_rdata;

  credit_counter credit_counter_inst (
    .clk          (clk),
    .rst          (rst),
    .issue_i      (issue),
    .credit_i     (mem_credit_i),
    .has_credit_o (has_credit)
  );

  bus_arbiter_fsm bus_arbiter_fsm_inst (
    .clk          (clk),
    .rst          (rst),
    .ifu_req_i    (ifu_req_i),
    .lsu_rd_req_i (lsu_rd_req_i),
    .lsu_wr_req_i (lsu_wr_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .has_credit_i (has_credit),
    .idle_i       (idle),
    .ifu_ack_o    (ifu_ack_o),
    .lsu_ack_o    (lsu_ack_o),
    .grant_o      (grant),
    .issue_o      (issue),
    .clint_rd_o   (clint_rd)
  );

  store_lane_align store_lane_align_inst (
    .grant_i     (grant),
    .ifu_addr_i  (ifu_addr_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_strb_i  (lsu_strb_i),
    .mem_addr_o  (mem_addr_o),
    .mem_size_o  (mem_size_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_wstrb_o (mem_wstrb_o),
    .mem_we_o    (mem_we_o)
  );

  // addr bit 2 of the issued request picks the response half later
  rsp_router rsp_router_inst (
    .clk              (clk),
    .rst              (rst),
    .push_i           (issue),
    .push_owner_i     (grant),
    .push_hi_i        (mem_addr_o[2]),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rdata_i      (mem_rdata_i),
    .idle_o           (idle),
    .ifu_rvalid_o     (ifu_rvalid_o),
    .ifu_rdata_o      (ifu_rdata_o),
    .lsu_mem_rvalid_o (rtr_lsu_rvalid),
    .lsu_mem_rdata_o  (rtr_lsu_rdata),
    .lsu_wdone_o      (lsu_wdone_o)
  );

  // high mtime word sits at the address with bit 2 set
  clint_timer clint_timer_inst (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .rd_hi_i  (lsu_addr_i[2]),
    .rvalid_o (clint_rvalid),
    .rdata_o  (clint_rdata)
  );

  assign mem_req_o = issue;

  // timer loads wait for an empty queue, so both sources never overlap
  assign lsu_rvalid_o = rtr_lsu_rvalid | clint_rvalid;
  assign lsu_rdata_o  = rtr_lsu_rdata | clint_rdata;

endmodule

`default_nettype wire

// File: design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_i,
  input  logic                 rd_hi_i,
  output logic                 rvalid_o,
  output bus_types_pkg::word_t rdata_o
);

  import bus_types_pkg::*;

  // machine timer, no compare or interrupt here
  logic [63:0] mtime_q;
  logic        rvalid_q;
  word_t       rdata_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;
      rvalid_q <= rd_i;
    end
  end

  // sample the value of the read cycle
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      rdata_q <= rd_hi_i ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rvalid_o = rvalid_q;
  // zero when idle so it can be ORed onto the lsu read data
  assign rdata_o = rvalid_q ? rdata_q : '0;

endmodule

`default_nettype wire

// File: design/rsp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_macros.svh"

module rsp_router (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push_i,
  input  arb_pkg::owner_t      push_owner_i,
  input  logic                 push_hi_i,
  input  logic                 mem_rsp_valid_i,
  input  bus_types_pkg::beat_t mem_rdata_i,
  output logic                 idle_o,
  output logic                 ifu_rvalid_o,
  output bus_types_pkg::word_t ifu_rdata_o,
  output logic                 lsu_mem_rvalid_o,
  output bus_types_pkg::word_t lsu_mem_rdata_o,
  output logic                 lsu_wdone_o
);

  import arb_pkg::*;
  import bus_types_pkg::*;

  localparam int q_depth = `MB_CREDITS;
  localparam int ptr_w = (q_depth > 1) ? $clog2(q_depth) : 1;

  // one slot per credit, so the queue cannot overflow
  owner_t             owner_mem [q_depth];
  logic               hi_mem [q_depth];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  logic [`MB_CREDIT_W-1:0] count_q;
  logic               pop;
  owner_t             head_owner;
  word_t              rsp_word;

  // responses come back in request order, head is the owner
  assign pop        = mem_rsp_valid_i && (count_q != '0);
  assign head_owner = owner_mem[rd_ptr_q];

  // pick the half holding the requested word
  assign rsp_word = hi_mem[rd_ptr_q] ? mem_rdata_i[63:32] : mem_rdata_i[31:0];

  assign ifu_rvalid_o     = pop && (head_owner == own_ifu_rd);
  assign lsu_mem_rvalid_o = pop && (head_owner == own_lsu_rd);
  assign lsu_wdone_o      = pop && (head_owner == own_lsu_wr);

  // data zeroed when not valid, top ORs the lsu side with the timer
  assign ifu_rdata_o     = ifu_rvalid_o ? rsp_word : '0;
  assign lsu_mem_rdata_o = lsu_mem_rvalid_o ? rsp_word : '0;

  assign idle_o = (count_q == '0);

  // queue storage
  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      owner_mem[wr_ptr_q] <= push_owner_i;
      hi_mem[wr_ptr_q]    <= push_hi_i;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(q_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(q_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop together leave the level alone
      if (push_i && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push_i)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/store_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_lane_align (
  input  arb_pkg::owner_t           grant_i,
  input  bus_types_pkg::addr_t      ifu_addr_i,
  input  bus_types_pkg::addr_t      lsu_addr_i,
  input  bus_types_pkg::word_t      lsu_wdata_i,
  input  bus_types_pkg::lane_strb_t lsu_strb_i,
  output bus_types_pkg::addr_t      mem_addr_o,
  output bus_types_pkg::size_t      mem_size_o,
  output bus_types_pkg::beat_t      mem_wdata_o,
  output bus_types_pkg::beat_strb_t mem_wstrb_o,
  output logic                      mem_we_o
);

  import arb_pkg::*;
  import bus_types_pkg::*;

  lane_strb_t base_strb;
  word_t      lane_wdata;

  // mask comes in already shifted, undo it to read the width
  assign base_strb = lsu_strb_i >> lsu_addr_i[1:0];

  // byte offset moves the store data onto its lanes
  assign lane_wdata = lsu_wdata_i << {lsu_addr_i[1:0], 3'b000};

  assign mem_addr_o = (grant_i == own_ifu_rd) ? ifu_addr_i : lsu_addr_i;
  assign mem_we_o   = (grant_i == own_lsu_wr);

  always_comb
  begin
    if (grant_i == own_ifu_rd)
    begin
      // fetch is always a full word
      mem_size_o = 3'd2;
    end
    else
    begin
      case (base_strb)
        4'b0001: mem_size_o = 3'd0;
        4'b0011: mem_size_o = 3'd1;
        4'b1111: mem_size_o = 3'd2;
        default: mem_size_o = 3'd0;
      endcase
    end
  end

  // same word in both halves, strobes pick the half by addr bit 2
  assign mem_wdata_o = {lane_wdata, lane_wdata};
  assign mem_wstrb_o = !mem_we_o     ? 8'h00 :
                       lsu_addr_i[2] ? {lsu_strb_i, 4'b0000} :
                                       {4'b0000, lsu_strb_i};

endmodule

`default_nettype wire

// File: design/bus_arbiter_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_macros.svh"

module bus_arbiter_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ifu_req_i,
  input  logic                 lsu_rd_req_i,
  input  logic                 lsu_wr_req_i,
  input  bus_types_pkg::addr_t lsu_addr_i,
  input  logic                 has_credit_i,
  input  logic                 idle_i,
  output logic                 ifu_ack_o,
  output logic                 lsu_ack_o,
  output arb_pkg::owner_t      grant_o,
  output logic                 issue_o,
  output logic                 clint_rd_o
);

  import arb_pkg::*;

  arb_state_t state_q;
  logic       clint_hit;
  logic       ifu_ok;
  logic       lsu_ok;
  logic       ifu_turn;
  logic       grant_ifu;
  logic       grant_lsu;

  // loads of either mtime word go to the local timer
  assign clint_hit = lsu_rd_req_i &&
                     ((lsu_addr_i == `MB_RTC_ADDR) || (lsu_addr_i == `MB_RTC_ADDR_UP));

  // fetch always needs a memory credit
  assign ifu_ok = ifu_req_i && has_credit_i;

  // timer load needs an empty owner queue to keep lsu responses in order
  // everything else needs a credit
  assign lsu_ok = clint_hit ? idle_i :
                  ((lsu_rd_req_i || lsu_wr_req_i) && has_credit_i);

  // lsu got the previous grant, so a waiting fetch goes first
  assign ifu_turn = (state_q == arb_lsu) || (state_q == arb_clint);

  assign grant_ifu = ifu_ok && (!lsu_ok || ifu_turn);
  assign grant_lsu = lsu_ok && !grant_ifu;

  assign ifu_ack_o = grant_ifu;
  assign lsu_ack_o = grant_lsu;

  // timer loads never reach memory
  assign issue_o    = grant_ifu || (grant_lsu && !clint_hit);
  assign clint_rd_o = grant_lsu && clint_hit;

  // owner of this cycle's request
  // timer load reports as lsu read, which only steers the address mux
  always_comb
  begin
    if (grant_lsu && lsu_wr_req_i)
    begin
      grant_o = own_lsu_wr;
    end
    else if (grant_lsu)
    begin
      grant_o = own_lsu_rd;
    end
    else
    begin
      grant_o = own_ifu_rd;
    end
  end

  // remember the last grant, hold it through empty cycles
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= arb_idle;
    end
    else if (grant_ifu)
    begin
      state_q <= arb_ifu;
    end
    else if (grant_lsu)
    begin
      state_q <= clint_hit ? arb_clint : arb_lsu;
    end
  end

endmodule

`default_nettype wire

// File: design/credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_macros.svh"

module credit_counter (
  input  logic clk,
  input  logic rst,
  input  logic issue_i,
  input  logic credit_i,
  output logic has_credit_o
);

  // free credits, full after reset
  logic [`MB_CREDIT_W-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count_q <= `MB_CREDIT_W'(`MB_CREDITS);
    end
    else if (issue_i && !credit_i)
    begin
      // request spent one credit
      count_q <= count_q - 1'b1;
    end
    else if (credit_i && !issue_i)
    begin
      // response handed one back
      count_q <= count_q + 1'b1;
    end
  end

  // only the registered count, returned credit counts next cycle
  assign has_credit_o = (count_q != '0);

endmodule

`default_nettype wire

// File: design/arb_pkg.sv
`default_nettype none

package arb_pkg;

  // last grant, kept by the arbiter for the fairness rule
  typedef enum logic [1:0] {arb_idle, arb_ifu, arb_lsu, arb_clint} arb_state_t;

  // who an outstanding memory request belongs to
  typedef enum logic [1:0] {own_ifu_rd, own_lsu_rd, own_lsu_wr} owner_t;

endpackage

`default_nettype wire

// File: design/bus_types_pkg.sv
`default_nettype none

package bus_types_pkg;

  // byte address seen by both ports
  typedef logic [31:0] addr_t;

  // core side data word
  typedef logic [31:0] word_t;

  // one beat on the memory channel
  typedef logic [63:0] beat_t;

  // byte mask of a core access
  typedef logic [3:0] lane_strb_t;

  // byte strobes on the memory beat
  typedef logic [7:0] beat_strb_t;

  // log2 of the access size in bytes
  typedef logic [2:0] size_t;

endpackage

`default_nettype wire

// File: design/mem_bus_macros.svh
`ifndef MEM_BUS_MACROS_SVH
`define MEM_BUS_MACROS_SVH

// credits granted by memory out of reset
// also sets the depth of the response owner queue
`define MB_CREDITS 4

// core-local timer, low word of mtime
`define MB_RTC_ADDR 32'h0200_BFF8

// core-local timer, high word of mtime
`define MB_RTC_ADDR_UP 32'h0200_BFFC

// counter width able to hold 0 .. MB_CREDITS
`define MB_CREDIT_W ($clog2(`MB_CREDITS + 1))

`endif
